/* hw/dcache_pkg.sv */
package dcache_pkg;

    // geometry
    localparam int PA_WIDTH     = 16;
    localparam int LINE_BYTES   = 16;
    localparam int LINE_WIDTH   = LINE_BYTES * 8;
    localparam int OFFSET_WIDTH = $clog2(LINE_BYTES);
    localparam int N_SETS       = 8;
    localparam int SET_WIDTH    = $clog2(N_SETS);
    localparam int N_WAYS       = 4;
    localparam int WAY_WIDTH    = $clog2(N_WAYS);
    localparam int TAG_WIDTH    = PA_WIDTH - SET_WIDTH - OFFSET_WIDTH;

    // controller states
    localparam int STATE_WIDTH = 3;
    localparam logic [STATE_WIDTH-1:0] C_IDLE      = 3'd0;
    localparam logic [STATE_WIDTH-1:0] C_LOOKUP    = 3'd1;
    localparam logic [STATE_WIDTH-1:0] C_WRITEBACK = 3'd2;
    localparam logic [STATE_WIDTH-1:0] C_REFILL    = 3'd3;
    localparam logic [STATE_WIDTH-1:0] C_RESPOND   = 3'd4;

    // lfsr seed, must be nonzero
    localparam logic [15:0] LFSR_SEED = 16'hace1;

    typedef enum logic [1:0] {
        SIZE_BYTE,
        SIZE_HALF,
        SIZE_WORD
    } size_e;

    // one address, seen raw or split into line fields
    typedef union packed {
        logic [PA_WIDTH-1:0] raw;
        struct packed {
            logic [TAG_WIDTH-1:0]    tag;
            logic [SET_WIDTH-1:0]    set;
            logic [OFFSET_WIDTH-1:0] offset;
        } f;
    } pa_u;

endpackage

/* hw/way_if.sv */
`timescale 1ns/1ns

interface way_if
    import dcache_pkg::*;
();

    // controller side
    logic [SET_WIDTH-1:0]  set_idx;
    logic [TAG_WIDTH-1:0]  lookup_tag;
    logic                  fill;
    logic [LINE_WIDTH-1:0] fill_line;
    logic [TAG_WIDTH-1:0]  fill_tag;
    logic                  store;
    logic [LINE_BYTES-1:0] store_mask;
    logic [LINE_WIDTH-1:0] store_line;
    logic                  victim_clr;

    // way side, all at set_idx
    logic                  hit;
    logic                  valid;
    logic                  dirty;
    logic [TAG_WIDTH-1:0]  tag;
    logic [LINE_WIDTH-1:0] line;

    modport ctrl (
        output set_idx, lookup_tag, fill, fill_line, fill_tag,
        output store, store_mask, store_line, victim_clr
    );

    modport way (
        input  set_idx, lookup_tag, fill, fill_line, fill_tag,
        input  store, store_mask, store_line, victim_clr,
        output hit, valid, dirty, tag, line
    );

    modport merge (
        input hit, valid, dirty, tag, line
    );

endinterface

/* hw/dcache_way.sv */
`timescale 1ns/1ns

module dcache_way
    import dcache_pkg::*;
(
    input logic  clk,
    input logic  rst,
    way_if.way   i_bus
);

    logic [TAG_WIDTH-1:0]  tag_mem  [N_SETS];
    logic [LINE_WIDTH-1:0] line_mem [N_SETS];
    logic [N_SETS-1:0]     valid_bits;
    logic [N_SETS-1:0]     dirty_bits;

    // lookup at the presented set
    assign i_bus.valid = valid_bits[i_bus.set_idx];
    assign i_bus.dirty = dirty_bits[i_bus.set_idx];
    assign i_bus.tag   = tag_mem[i_bus.set_idx];
    assign i_bus.line  = line_mem[i_bus.set_idx];
    assign i_bus.hit   = i_bus.valid && (i_bus.tag == i_bus.lookup_tag);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_bits <= '0;
            dirty_bits <= '0;
        end else begin
            if (i_bus.victim_clr) begin
                valid_bits[i_bus.set_idx] <= 1'b0;
                dirty_bits[i_bus.set_idx] <= 1'b0;
            end
            if (i_bus.fill) begin
                valid_bits[i_bus.set_idx] <= 1'b1; // refilled lines start clean
                dirty_bits[i_bus.set_idx] <= 1'b0;
            end
            if (i_bus.store) begin
                dirty_bits[i_bus.set_idx] <= 1'b1;
            end
        end
    end

    // data and tag arrays
    always_ff @(posedge clk) begin
        if (i_bus.fill) begin
            tag_mem[i_bus.set_idx]  <= i_bus.fill_tag;
            line_mem[i_bus.set_idx] <= i_bus.fill_line;
        end else if (i_bus.store) begin
            for (int b = 0; b < LINE_BYTES; b++) begin
                if (i_bus.store_mask[b]) begin
                    line_mem[i_bus.set_idx][b*8 +: 8] <= i_bus.store_line[b*8 +: 8];
                end
            end
        end
    end

endmodule

/* hw/dcache_ctrl.sv */
`timescale 1ns/1ns

module dcache_ctrl
    import dcache_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst,

    input  logic                    i_req_valid,
    input  logic                    i_req_write,
    input  size_e                   i_req_size,
    input  logic                    i_req_unsigned,
    input  logic [PA_WIDTH-1:0]     i_req_addr,
    input  logic [31:0]             i_req_wdata,

    output logic                    o_resp_valid,
    output logic                    o_resp_hit,
    output logic [31:0]             o_resp_rdata,

    output logic                    o_mem_rd,
    output logic                    o_mem_wr,
    output logic [PA_WIDTH-1:0]     o_mem_addr,
    output logic [LINE_WIDTH-1:0]   o_mem_wdata,
    input  logic                    i_mem_valid,
    input  logic [LINE_WIDTH-1:0]   i_mem_rdata,

    way_if.ctrl                     o_ways [N_WAYS],

    input  logic                    i_any_hit,
    input  logic [WAY_WIDTH-1:0]    i_hit_way,
    input  logic                    i_victim_dirty,
    input  logic [TAG_WIDTH-1:0]    i_victim_tag,
    input  logic [LINE_WIDTH-1:0]   i_victim_line,
    input  logic [31:0]             i_load_data,

    output logic [WAY_WIDTH-1:0]    o_victim_way,
    output logic [OFFSET_WIDTH-1:0] o_req_offset,
    output size_e                   o_req_size,
    output logic                    o_req_unsigned
);

    logic [STATE_WIDTH-1:0] state;
    logic [15:0]            lfsr;
    logic                   lfsr_fb;
    logic [WAY_WIDTH-1:0]   victim_q;
    logic                   missed;

    pa_u                    req_addr;
    logic                   req_write;
    logic [31:0]            req_wdata;
    pa_u                    req_line;
    pa_u                    victim_pa;

    logic                   miss_now;
    logic                   fill_now;
    logic                   store_now;
    logic [3:0]             base_mask;
    logic [31:0]            word_rep;
    logic [LINE_BYTES-1:0]  store_mask;
    logic [LINE_WIDTH-1:0]  store_line;

    assign lfsr_fb      = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
    assign o_victim_way = lfsr[WAY_WIDTH-1:0];
    assign o_req_offset = req_addr.f.offset;

    assign miss_now  = (state == C_LOOKUP) && !i_any_hit;
    assign fill_now  = (state == C_REFILL) && i_mem_valid;
    assign store_now = (state == C_RESPOND) && req_write && i_any_hit;

    assign req_line.raw = {req_addr.raw[PA_WIDTH-1:OFFSET_WIDTH], {OFFSET_WIDTH{1'b0}}};

    always_comb begin
        victim_pa.f.tag    = i_victim_tag;
        victim_pa.f.set    = req_addr.f.set;
        victim_pa.f.offset = '0;
    end

    // store merge, data replicated across the line
    always_comb begin
        case (o_req_size)
            SIZE_BYTE: begin
                base_mask = 4'b0001;
                word_rep  = {4{req_wdata[7:0]}};
            end
            SIZE_HALF: begin
                base_mask = 4'b0011;
                word_rep  = {2{req_wdata[15:0]}};
            end
            default: begin
                base_mask = 4'b1111;
                word_rep  = req_wdata;
            end
        endcase
        store_mask = LINE_BYTES'(base_mask) << req_addr.f.offset;
        store_line = {(LINE_BYTES / 4){word_rep}};
    end

    for (genvar w = 0; w < N_WAYS; w++) begin : g_way_drv
        assign o_ways[w].set_idx    = req_addr.f.set;
        assign o_ways[w].lookup_tag = req_addr.f.tag;
        assign o_ways[w].fill       = fill_now && (victim_q == WAY_WIDTH'(w));
        assign o_ways[w].fill_line  = i_mem_rdata;
        assign o_ways[w].fill_tag   = req_addr.f.tag;
        assign o_ways[w].store      = store_now && (i_hit_way == WAY_WIDTH'(w));
        assign o_ways[w].store_mask = store_mask;
        assign o_ways[w].store_line = store_line;
        assign o_ways[w].victim_clr = miss_now && (o_victim_way == WAY_WIDTH'(w));
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state        <= C_IDLE;
            lfsr         <= LFSR_SEED;
            victim_q     <= '0;
            missed       <= 1'b0;
            o_resp_valid <= 1'b0;
            o_resp_hit   <= 1'b0;
            o_mem_rd     <= 1'b0;
            o_mem_wr     <= 1'b0;
        end else begin
            lfsr         <= {lfsr[14:0], lfsr_fb};
            o_resp_valid <= 1'b0;
            o_mem_rd     <= 1'b0;
            o_mem_wr     <= 1'b0;
            case (state)
                C_IDLE: begin
                    if (i_req_valid) begin
                        missed <= 1'b0;
                        state  <= C_LOOKUP;
                    end
                end
                C_LOOKUP: begin
                    if (i_any_hit) begin
                        state <= C_RESPOND;
                    end else begin
                        missed   <= 1'b1;
                        victim_q <= o_victim_way;
                        if (i_victim_dirty) begin
                            o_mem_wr <= 1'b1; // evict first
                            state    <= C_WRITEBACK;
                        end else begin
                            o_mem_rd <= 1'b1;
                            state    <= C_REFILL;
                        end
                    end
                end
                C_WRITEBACK: begin
                    o_mem_rd <= 1'b1;
                    state    <= C_REFILL;
                end
                C_REFILL: begin
                    if (i_mem_valid) begin
                        state <= C_LOOKUP; // replay
                    end
                end
                C_RESPOND: begin
                    o_resp_valid <= 1'b1;
                    o_resp_hit   <= !missed;
                    state        <= C_IDLE;
                end
                default: begin
                    state <= C_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == C_IDLE && i_req_valid) begin
            req_addr.raw   <= i_req_addr;
            req_write      <= i_req_write;
            o_req_size     <= i_req_size;
            o_req_unsigned <= i_req_unsigned;
            req_wdata      <= i_req_wdata;
        end
        if (miss_now) begin
            o_mem_addr  <= i_victim_dirty ? victim_pa.raw : req_line.raw;
            o_mem_wdata <= i_victim_line;
        end else if (state == C_WRITEBACK) begin
            o_mem_addr <= req_line.raw;
        end
        if (state == C_RESPOND) begin
            o_resp_rdata <= i_load_data;
        end
    end

endmodule

/* hw/hit_merge.sv */
`timescale 1ns/1ns

module hit_merge
    import dcache_pkg::*;
(
    way_if.merge                    i_ways [N_WAYS],

    input  logic [WAY_WIDTH-1:0]    i_victim_way,
    input  logic [OFFSET_WIDTH-1:0] i_req_offset,
    input  size_e                   i_req_size,
    input  logic                    i_req_unsigned,

    output logic                    o_any_hit,
    output logic [WAY_WIDTH-1:0]    o_hit_way,
    output logic                    o_victim_dirty,
    output logic [TAG_WIDTH-1:0]    o_victim_tag,
    output logic [LINE_WIDTH-1:0]   o_victim_line,
    output logic [31:0]             o_load_data
);

    logic [N_WAYS-1:0]     hits;
    logic [N_WAYS-1:0]     valids;
    logic [N_WAYS-1:0]     dirties;
    logic [TAG_WIDTH-1:0]  tags  [N_WAYS];
    logic [LINE_WIDTH-1:0] lines [N_WAYS];

    logic [LINE_WIDTH-1:0] hit_line;
    logic [6:0]            bit_base;
    logic [31:0]           word_read;
    logic [15:0]           half_read;
    logic [7:0]            byte_read;

    // flatten the interface array so it can be muxed by index
    for (genvar w = 0; w < N_WAYS; w++) begin : g_flat
        assign hits[w]    = i_ways[w].hit;
        assign valids[w]  = i_ways[w].valid;
        assign dirties[w] = i_ways[w].dirty;
        assign tags[w]    = i_ways[w].tag;
        assign lines[w]   = i_ways[w].line;
    end

    assign o_any_hit = |hits;

    always_comb begin
        o_hit_way = '0;
        for (int w = N_WAYS - 1; w >= 0; w--) begin
            if (hits[w]) begin
                o_hit_way = WAY_WIDTH'(w); // lowest way wins
            end
        end
    end

    assign hit_line       = lines[o_hit_way];
    assign o_victim_dirty = valids[i_victim_way] && dirties[i_victim_way];
    assign o_victim_tag   = tags[i_victim_way];
    assign o_victim_line  = lines[i_victim_way];

    // little endian, aligned only
    assign bit_base  = {i_req_offset, 3'b000};
    assign word_read = hit_line[bit_base +: 32];
    assign half_read = hit_line[bit_base +: 16];
    assign byte_read = hit_line[bit_base +: 8];

    always_comb begin
        case (i_req_size)
            SIZE_BYTE: o_load_data = {{24{byte_read[7] & !i_req_unsigned}}, byte_read};
            SIZE_HALF: o_load_data = {{16{half_read[15] & !i_req_unsigned}}, half_read};
            default:   o_load_data = word_read;
        endcase
    end

endmodule

/* hw/dcache_top.sv */
`timescale 1ns/1ns

module dcache_top
    import dcache_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,

    input  logic                  i_req_valid,
    input  logic                  i_req_write,
    input  size_e                 i_req_size,
    input  logic                  i_req_unsigned,
    input  logic [PA_WIDTH-1:0]   i_req_addr,
    input  logic [31:0]           i_req_wdata,

    output logic                  o_resp_valid,
    output logic                  o_resp_hit,
    output logic [31:0]           o_resp_rdata,

    output logic                  o_mem_rd,
    output logic                  o_mem_wr,
    output logic [PA_WIDTH-1:0]   o_mem_addr,
    output logic [LINE_WIDTH-1:0] o_mem_wdata,
    input  logic                  i_mem_valid,
    input  logic [LINE_WIDTH-1:0] i_mem_rdata
);

    way_if ways [N_WAYS] ();

    logic                    any_hit;
    logic [WAY_WIDTH-1:0]    hit_way;
    logic                    victim_dirty;
    logic [TAG_WIDTH-1:0]    victim_tag;
    logic [LINE_WIDTH-1:0]   victim_line;
    logic [31:0]             load_data;
    logic [WAY_WIDTH-1:0]    victim_way;
    logic [OFFSET_WIDTH-1:0] req_offset;
    size_e                   req_size;
    logic                    req_unsigned;

    dcache_ctrl ctrl0 (
        .clk            (clk),
        .rst            (rst),
        .i_req_valid    (i_req_valid),
        .i_req_write    (i_req_write),
        .i_req_size     (i_req_size),
        .i_req_unsigned (i_req_unsigned),
        .i_req_addr     (i_req_addr),
        .i_req_wdata    (i_req_wdata),
        .o_resp_valid   (o_resp_valid),
        .o_resp_hit     (o_resp_hit),
        .o_resp_rdata   (o_resp_rdata),
        .o_mem_rd       (o_mem_rd),
        .o_mem_wr       (o_mem_wr),
        .o_mem_addr     (o_mem_addr),
        .o_mem_wdata    (o_mem_wdata),
        .i_mem_valid    (i_mem_valid),
        .i_mem_rdata    (i_mem_rdata),
        .o_ways         (ways),
        .i_any_hit      (any_hit),
        .i_hit_way      (hit_way),
        .i_victim_dirty (victim_dirty),
        .i_victim_tag   (victim_tag),
        .i_victim_line  (victim_line),
        .i_load_data    (load_data),
        .o_victim_way   (victim_way),
        .o_req_offset   (req_offset),
        .o_req_size     (req_size),
        .o_req_unsigned (req_unsigned)
    );

    for (genvar g = 0; g < N_WAYS; g++) begin : g_way
        dcache_way way0 (
            .clk   (clk),
            .rst   (rst),
            .i_bus (ways[g])
        );
    end

    hit_merge merge0 (
        .i_ways         (ways),
        .i_victim_way   (victim_way),
        .i_req_offset   (req_offset),
        .i_req_size     (req_size),
        .i_req_unsigned (req_unsigned),
        .o_any_hit      (any_hit),
        .o_hit_way      (hit_way),
        .o_victim_dirty (victim_dirty),
        .o_victim_tag   (victim_tag),
        .o_victim_line  (victim_line),
        .o_load_data    (load_data)
    );

endmodule

/* test/dcache_sva.sv */
`timescale 1ns/1ns

module dcache_sva
    import dcache_pkg::*;
(
    input logic                clk,
    input logic                rst,
    input logic                i_resp_valid,
    input logic                i_mem_rd,
    input logic                i_mem_wr,
    input logic [PA_WIDTH-1:0] i_mem_addr
);

    // one memory command per cycle
    a_rd_wr_exclusive: assert property (@(posedge clk) disable iff (rst)
        !(i_mem_rd && i_mem_wr))
        else $error("memory read and write strobes high together");

    a_line_aligned: assert property (@(posedge clk) disable iff (rst)
        (i_mem_rd || i_mem_wr) |-> (i_mem_addr[OFFSET_WIDTH-1:0] == '0))
        else $error("memory address is not line aligned");

    a_resp_not_on_rd: assert property (@(posedge clk) disable iff (rst)
        !(i_resp_valid && i_mem_rd))
        else $error("response and memory read in the same cycle");

    a_quiet_in_reset: assert property (@(posedge clk)
        rst |-> (!i_resp_valid && !i_mem_rd && !i_mem_wr))
        else $error("strobe high during reset");

endmodule

bind dcache_top dcache_sva sva0 (
    .clk          (clk),
    .rst          (rst),
    .i_resp_valid (o_resp_valid),
    .i_mem_rd     (o_mem_rd),
    .i_mem_wr     (o_mem_wr),
    .i_mem_addr   (o_mem_addr)
);

/* test/tb_dcache.sv */
`timescale 1ns/1ns

module tb_dcache;
    import dcache_pkg::*;

    localparam int N_REQ   = 250;
    localparam int TIMEOUT = 200;
    localparam int N_LINES = 2 ** (PA_WIDTH - OFFSET_WIDTH);

    logic                  clk;
    logic                  rst;
    logic                  i_req_valid;
    logic                  i_req_write;
    size_e                 i_req_size;
    logic                  i_req_unsigned;
    logic [PA_WIDTH-1:0]   i_req_addr;
    logic [31:0]           i_req_wdata;
    logic                  o_resp_valid;
    logic                  o_resp_hit;
    logic [31:0]           o_resp_rdata;
    logic                  o_mem_rd;
    logic                  o_mem_wr;
    logic [PA_WIDTH-1:0]   o_mem_addr;
    logic [LINE_WIDTH-1:0] o_mem_wdata;
    logic                  i_mem_valid;
    logic [LINE_WIDTH-1:0] i_mem_rdata;

    logic [7:0]            model_mem [2**PA_WIDTH]; // architectural bytes
    logic [LINE_WIDTH-1:0] back_mem  [N_LINES];     // memory behind the cache
    logic                  touched   [N_LINES];
    logic [31:0]           rng;
    pa_u                   prev_line;

    dcache_top dut0 (
        .clk            (clk),
        .rst            (rst),
        .i_req_valid    (i_req_valid),
        .i_req_write    (i_req_write),
        .i_req_size     (i_req_size),
        .i_req_unsigned (i_req_unsigned),
        .i_req_addr     (i_req_addr),
        .i_req_wdata    (i_req_wdata),
        .o_resp_valid   (o_resp_valid),
        .o_resp_hit     (o_resp_hit),
        .o_resp_rdata   (o_resp_rdata),
        .o_mem_rd       (o_mem_rd),
        .o_mem_wr       (o_mem_wr),
        .o_mem_addr     (o_mem_addr),
        .o_mem_wdata    (o_mem_wdata),
        .i_mem_valid    (i_mem_valid),
        .i_mem_rdata    (i_mem_rdata)
    );

    always #2 clk = ~clk;

    function automatic logic [31:0] next_rand();
        rng = rng * 32'd1664525 + 32'd1013904223;
        return rng;
    endfunction

    function automatic logic [7:0] fill_byte(logic [PA_WIDTH-1:0] a);
        return (a[7:0] * 8'd7) ^ a[15:8] ^ 8'h3c;
    endfunction

    function automatic int size_bytes(size_e s);
        return (s == SIZE_BYTE) ? 1 : (s == SIZE_HALF) ? 2 : 4;
    endfunction

    function automatic size_e pick_size(logic [1:0] code);
        return (code == 2'd3) ? SIZE_WORD : size_e'(code);
    endfunction

    // 3 sets x 6 tags against 4 ways
    function automatic pa_u pick_addr(size_e s);
        pa_u         a;
        logic [31:0] r;
        r = next_rand();
        a.f.tag    = TAG_WIDTH'((r[23:16] % 6) * 37 + 5);
        a.f.set    = SET_WIDTH'((r[31:24] % 3) * 3 + 1);
        a.f.offset = r[11:8] & ~OFFSET_WIDTH'(size_bytes(s) - 1);
        return a;
    endfunction

    function automatic logic [LINE_WIDTH-1:0] model_line(pa_u line_a);
        logic [LINE_WIDTH-1:0] l;
        for (int b = 0; b < LINE_BYTES; b++) begin
            l[b*8 +: 8] = model_mem[line_a.raw + b];
        end
        return l;
    endfunction

    function automatic logic [31:0] expected_load(pa_u a, size_e s, logic uns);
        logic [31:0] v;
        int          n;
        logic        msb;
        n = size_bytes(s);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v[i*8 +: 8] = model_mem[a.raw + i];
        end
        msb = v[n*8-1] & !uns;
        for (int i = n * 8; i < 32; i++) begin
            v[i] = msb;
        end
        return v;
    endfunction

    task automatic store_model(pa_u a, size_e s, logic [31:0] data);
        for (int i = 0; i < size_bytes(s); i++) begin
            model_mem[a.raw + i] = data[i*8 +: 8];
        end
    endtask

    task automatic abort_run();
        $display("sim failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_data(string name, logic [31:0] exp, logic [31:0] act);
        if (act !== exp) begin
            $display("MISMATCH %s expected %h actual %h", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_line(string name, logic [LINE_WIDTH-1:0] exp,
                              logic [LINE_WIDTH-1:0] act);
        if (act !== exp) begin
            $display("MISMATCH %s expected %h actual %h", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_addr(string name, pa_u exp, pa_u act);
        if (act.raw !== exp.raw) begin
            $display("MISMATCH %s expected %h actual %h", name, exp.raw, act.raw);
            abort_run();
        end
    endtask

    task automatic check_flag(string name, logic exp, logic act);
        if (act !== exp) begin
            $display("MISMATCH %s expected %h actual %h", name, exp, act);
            abort_run();
        end
    endtask

    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    task automatic idle_cycles(int n);
        repeat (n) begin
            tick();
            check_flag("o_mem_rd", 1'b0, o_mem_rd);
            check_flag("o_mem_wr", 1'b0, o_mem_wr);
            check_flag("o_resp_valid", 1'b0, o_resp_valid);
        end
    endtask

    task automatic accept_write(pa_u line_a);
        pa_u wb_addr;
        wb_addr.raw = o_mem_addr;
        if (wb_addr.f.set !== line_a.f.set || wb_addr.f.tag === line_a.f.tag) begin
            $display("write-back address %h is not another line in the set of %h",
                     wb_addr.raw, line_a.raw);
            abort_run();
        end
        if (!touched[wb_addr.raw[PA_WIDTH-1:OFFSET_WIDTH]]) begin
            $display("write-back of a line that was never cached, address %h", wb_addr.raw);
            abort_run();
        end
        check_line("o_mem_wdata", model_line(wb_addr), o_mem_wdata);
        back_mem[wb_addr.raw[PA_WIDTH-1:OFFSET_WIDTH]] = o_mem_wdata;
    endtask

    // answer a line read 3 to 10 cycles later
    task automatic serve_read(pa_u line_a);
        logic [31:0] r;
        int          delay;
        r = next_rand();
        delay = 3 + int'(r[18:16]);
        idle_cycles(delay - 1);
        i_mem_valid = 1'b1;
        i_mem_rdata = back_mem[line_a.raw[PA_WIDTH-1:OFFSET_WIDTH]];
        tick();
        i_mem_valid = 1'b0;
    endtask

    task automatic run_request(logic wr, size_e s, logic uns, pa_u a, logic [31:0] wdata);
        pa_u         line_a;
        logic [31:0] exp_data;
        logic        saw_rd;
        logic        done;
        int          n;
        int          w;
        line_a.raw = {a.raw[PA_WIDTH-1:OFFSET_WIDTH], {OFFSET_WIDTH{1'b0}}};
        exp_data = expected_load(a, s, uns);
        if (wr) begin
            store_model(a, s, wdata);
        end
        i_req_valid    = 1'b1;
        i_req_write    = wr;
        i_req_size     = s;
        i_req_unsigned = uns;
        i_req_addr     = a.raw;
        i_req_wdata    = wdata;
        tick();
        i_req_valid = 1'b0;
        check_flag("o_resp_valid", 1'b0, o_resp_valid);
        check_flag("o_mem_rd", 1'b0, o_mem_rd);
        check_flag("o_mem_wr", 1'b0, o_mem_wr);
        saw_rd = 1'b0;
        done   = 1'b0;
        n      = 0;
        while (!done) begin
            if (n == TIMEOUT) begin
                $display("no response within %0d cycles for address %h", TIMEOUT, a.raw);
                abort_run();
            end
            tick();
            n++;
            if (o_mem_wr) begin
                accept_write(line_a);
                w = 0;
                while (!o_mem_rd) begin
                    if (w == TIMEOUT) begin
                        $display("write-back was not followed by a line read");
                        abort_run();
                    end
                    tick();
                    w++;
                end
            end
            if (o_mem_rd) begin
                saw_rd = 1'b1;
                check_addr("o_mem_addr", line_a, o_mem_addr);
                serve_read(line_a);
            end
            done = o_resp_valid;
        end
        if (!touched[line_a.raw[PA_WIDTH-1:OFFSET_WIDTH]]) begin
            check_flag("o_resp_hit", 1'b0, o_resp_hit); // cold line
        end else if (line_a.raw == prev_line.raw) begin
            check_flag("o_resp_hit", 1'b1, o_resp_hit);
        end
        check_flag("o_resp_hit", !saw_rd, o_resp_hit);
        if (!wr) begin
            check_data("o_resp_rdata", exp_data, o_resp_rdata);
        end
        touched[line_a.raw[PA_WIDTH-1:OFFSET_WIDTH]] = 1'b1;
        prev_line = line_a;
    endtask

    initial begin
        pa_u         a;
        pa_u         b;
        pa_u         prev_addr;
        logic [31:0] r;
        size_e       s;
        clk            = 1'b0;
        rst            = 1'b1;
        i_req_valid    = 1'b0;
        i_req_write    = 1'b0;
        i_req_size     = SIZE_BYTE;
        i_req_unsigned = 1'b0;
        i_req_addr     = '0;
        i_req_wdata    = '0;
        i_mem_valid    = 1'b0;
        i_mem_rdata    = '0;
        rng            = 32'h112b_975c;
        prev_line.raw  = '1; // all ones never matches an aligned line
        prev_addr.raw  = '0;
        for (int i = 0; i < 2 ** PA_WIDTH; i++) begin
            model_mem[i] = fill_byte(PA_WIDTH'(i));
        end
        for (int l = 0; l < N_LINES; l++) begin
            a.raw = PA_WIDTH'(l * LINE_BYTES);
            back_mem[l] = model_line(a);
            touched[l]  = 1'b0;
        end
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
        idle_cycles(3);

        for (int i = 0; i < N_REQ; i++) begin
            r = next_rand();
            s = pick_size(r[9:8]);
            if (i > 0 && r[7:6] == 2'd0) begin
                // reuse the previous word
                a.raw      = {prev_addr.raw[PA_WIDTH-1:2], 2'b00};
                a.raw[1:0] = r[5:4] & ~2'(size_bytes(s) - 1);
            end else begin
                a = pick_addr(s);
            end
            run_request(r[31], s, r[30], a, next_rand());
            prev_addr = a;
            idle_cycles((r[13:12] == 2'd0) ? 1 : 0);
        end

        // store a word and read it back with every size and sign
        for (int k = 0; k < 4; k++) begin
            a = pick_addr(SIZE_WORD);
            if (k[0]) begin
                run_request(1'b0, SIZE_WORD, 1'b0, a, 32'h0); // store will hit
            end else begin
                a.f.tag = TAG_WIDTH'(400 + k); // fresh tag so the store misses
            end
            run_request(1'b1, SIZE_WORD, 1'b0, a, next_rand() | 32'h8080_8080);
            for (int sz = 0; sz < 3; sz++) begin
                for (int u = 0; u < 2; u++) begin
                    for (int off = 0; off < 4; off += size_bytes(size_e'(sz))) begin
                        b.raw = a.raw + PA_WIDTH'(off);
                        run_request(1'b0, size_e'(sz), u[0], b, 32'h0);
                    end
                end
            end
        end
        idle_cycles(4);
        $display("sim passed");
        $finish;
    end

endmodule

/* sim.f */
hw/dcache_pkg.sv
hw/way_if.sv
hw/dcache_way.sv
hw/dcache_ctrl.sv
hw/hit_merge.sv
hw/dcache_top.sv
test/dcache_sva.sv
test/tb_dcache.sv
